/* verilog/iq_pkg.sv */
package iq_pkg;

  parameter int IQ_DEPTH = 8; // Default queue depth, a power of two.

  typedef enum logic [2:0] {
    OP_ALU,
    OP_MUL,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH
  } iq_op_e;

  // Unit stored in the queue and presented at the issue slots.
  typedef struct packed {
    iq_op_e      op;
    logic [3:0]  tag;
    logic [15:0] payload;
  } iq_entry_t;

  function automatic logic is_mem_op(input iq_op_e op);
    logic mem;
    mem = (op == OP_LOAD) || (op == OP_STORE);
    return mem;
  endfunction

endpackage

/* verilog/iq_if.sv */
interface iq_if #(
  parameter int ENTRY_COUNT = iq_pkg::IQ_DEPTH
) ();

  logic                         push0;
  logic                         push1;
  iq_pkg::iq_entry_t            push_entry0;
  iq_pkg::iq_entry_t            push_entry1;
  logic                         pop0;
  logic                         pop1;
  iq_pkg::iq_entry_t            head0; // Oldest entry.
  iq_pkg::iq_entry_t            head1;
  logic [$clog2(ENTRY_COUNT):0] count;

  modport disp (
    output push0,
    output push1,
    output push_entry0,
    output push_entry1,
    input  count
  );

  modport queue (
    input  push0,
    input  push1,
    input  push_entry0,
    input  push_entry1,
    input  pop0,
    input  pop1,
    output head0,
    output head1,
    output count
  );

  modport issue (
    input  head0,
    input  head1,
    input  count,
    output pop0,
    output pop1
  );

endinterface

/* verilog/iq_cfg_regs.sv */
module iq_cfg_regs #(
  parameter int ENTRY_COUNT = iq_pkg::IQ_DEPTH
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         cfg_we,
  input  logic                         cfg_addr,
  input  logic [7:0]                   cfg_wdata,
  output logic [$clog2(ENTRY_COUNT):0] limit,
  output logic                         dual_en
);

  localparam int CW = $clog2(ENTRY_COUNT) + 1;

  logic [CW-1:0] limit_next;

  // Clamp the written limit into 1..ENTRY_COUNT.
  always_comb begin
    if (cfg_wdata == 8'd0) begin
      limit_next = CW'(1);
    end else if (int'(cfg_wdata) > ENTRY_COUNT) begin
      limit_next = CW'(ENTRY_COUNT);
    end else begin
      limit_next = cfg_wdata[CW-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      limit   <= CW'(ENTRY_COUNT); // Full depth.
      dual_en <= 1'b1;
    end else if (cfg_we) begin
      if (cfg_addr == 1'b0) begin
        limit <= limit_next;
      end else begin
        dual_en <= cfg_wdata[0];
      end
    end
  end

endmodule

/* verilog/dispatch_port.sv */
module dispatch_port #(
  parameter int ENTRY_COUNT = iq_pkg::IQ_DEPTH
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         req,
  input  logic                         two,
  input  iq_pkg::iq_entry_t            entry0,
  input  iq_pkg::iq_entry_t            entry1,
  output logic                         ack,
  input  logic [$clog2(ENTRY_COUNT):0] limit,
  iq_if.disp                           q
);

  localparam int CW = $clog2(ENTRY_COUNT) + 1;

  logic [CW:0] need;
  logic        fits;
  logic        do_push;

  // Occupancy after this bundle lands, one bit wider to avoid wrap.
  assign need = {1'b0, q.count} + (two ? (CW+1)'(2) : (CW+1)'(1));
  assign fits = need <= {1'b0, limit};

  // One push per handshake, only while ack is still low.
  assign do_push = req && !ack && fits;

  assign q.push0       = do_push;
  assign q.push1       = do_push && two;
  assign q.push_entry0 = entry0;
  assign q.push_entry1 = entry1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
    end else if (do_push) begin
      ack <= 1'b1; // Rises at the push edge.
    end else if (!req) begin
      ack <= 1'b0; // Return to zero after req drops.
    end
  end

  // The source keeps req up until it has seen ack.
  a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
    req && !ack |=> req)
    else $error("disp_req dropped before disp_ack");

  // A new request must wait for ack to fall.
  a_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
    !req && ack |=> !req)
    else $error("disp_req rose while disp_ack still high");

endmodule

/* verilog/issue_queue.sv */
module issue_queue #(
  parameter int ENTRY_COUNT = iq_pkg::IQ_DEPTH
) (
  input  logic clk,
  input  logic arst_n,
  input  logic flush,
  iq_if.queue  q
);

  localparam int AW = $clog2(ENTRY_COUNT);

  iq_pkg::iq_entry_t mem [ENTRY_COUNT];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count_q;
  logic [1:0]    n_push;
  logic [1:0]    n_pop;

  assign n_push = 2'(q.push0) + 2'(q.push1);
  assign n_pop  = 2'(q.pop0) + 2'(q.pop1);

  // Entry storage.
  always_ff @(posedge clk) begin
    if (q.push0) begin
      mem[wr_ptr] <= q.push_entry0;
    end
    if (q.push1) begin
      mem[wr_ptr + AW'(1)] <= q.push_entry1; // Wraps with the pointer.
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else if (flush) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      wr_ptr  <= wr_ptr + AW'(n_push);
      rd_ptr  <= rd_ptr + AW'(n_pop);
      count_q <= count_q + (AW+1)'(n_push) - (AW+1)'(n_pop);
    end
  end

  assign q.head0 = mem[rd_ptr];
  assign q.head1 = mem[rd_ptr + AW'(1)];
  assign q.count = count_q;

  // Dispatch sizes its bundle against the count before this cycle's pops.
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    !flush |-> (int'(count_q) + int'(n_push)) <= ENTRY_COUNT)
    else $error("push beyond queue depth");

  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
    !flush |-> (AW+1)'(n_pop) <= count_q)
    else $error("pop beyond queue count");

  a_push_order: assert property (@(posedge clk) disable iff (!arst_n)
    q.push1 |-> q.push0)
    else $error("push1 without push0");

  a_pop_order: assert property (@(posedge clk) disable iff (!arst_n)
    q.pop1 |-> q.pop0)
    else $error("pop1 without pop0");

endmodule

/* verilog/issue_select.sv */
module issue_select (
  input  logic              issue_ready,
  input  logic              dual_en,
  iq_if.issue               q,
  output logic              vld0,
  output logic              vld1,
  output iq_pkg::iq_entry_t entry0,
  output iq_pkg::iq_entry_t entry1
);

  logic two_avail;
  logic mem_pair;

  assign two_avail = q.count >= 2;

  // Two memory operations never go out together.
  assign mem_pair = iq_pkg::is_mem_op(q.head0.op) && iq_pkg::is_mem_op(q.head1.op);

  assign vld0 = q.count >= 1;
  assign vld1 = two_avail && dual_en && !mem_pair;

  assign entry0 = q.head0;
  assign entry1 = q.head1;

  // Slot 1 only consumes together with slot 0, keeping program order.
  assign q.pop0 = vld0 && issue_ready;
  assign q.pop1 = vld1 && issue_ready;

endmodule

/* verilog/iq_top.sv */
module iq_top #(
  parameter int ENTRY_COUNT = iq_pkg::IQ_DEPTH
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         disp_req,
  input  logic                         disp_two,
  input  iq_pkg::iq_entry_t            disp_entry0,
  input  iq_pkg::iq_entry_t            disp_entry1,
  output logic                         disp_ack,
  input  logic                         issue_ready,
  output logic                         issue_vld0,
  output logic                         issue_vld1,
  output iq_pkg::iq_entry_t            issue_entry0,
  output iq_pkg::iq_entry_t            issue_entry1,
  input  logic                         cfg_we,
  input  logic                         cfg_addr,
  input  logic [7:0]                   cfg_wdata,
  input  logic                         flush,
  output logic [$clog2(ENTRY_COUNT):0] iq_count
);

  logic [$clog2(ENTRY_COUNT):0] limit;
  logic                         dual_en;

  iq_if #(.ENTRY_COUNT(ENTRY_COUNT)) q_if ();

  iq_cfg_regs #(.ENTRY_COUNT(ENTRY_COUNT)) u_cfg (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .limit     (limit),
    .dual_en   (dual_en)
  );

  dispatch_port #(.ENTRY_COUNT(ENTRY_COUNT)) u_disp (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (disp_req),
    .two    (disp_two),
    .entry0 (disp_entry0),
    .entry1 (disp_entry1),
    .ack    (disp_ack),
    .limit  (limit),
    .q      (q_if.disp)
  );

  issue_queue #(.ENTRY_COUNT(ENTRY_COUNT)) u_queue (
    .clk    (clk),
    .arst_n (arst_n),
    .flush  (flush),
    .q      (q_if.queue)
  );

  issue_select u_sel (
    .issue_ready (issue_ready),
    .dual_en     (dual_en),
    .q           (q_if.issue),
    .vld0        (issue_vld0),
    .vld1        (issue_vld1),
    .entry0      (issue_entry0),
    .entry1      (issue_entry1)
  );

  assign iq_count = q_if.count;

endmodule

/* verif/tb_iq_top.sv */
module tb_iq_top;

  localparam int DEPTH = iq_pkg::IQ_DEPTH;
  localparam int CW = $clog2(DEPTH) + 1;
  localparam int WAIT_LIMIT = 200;

  logic              clk, arst_n;
  logic              disp_req, disp_two, disp_ack;
  iq_pkg::iq_entry_t disp_entry0, disp_entry1;
  logic              issue_ready, issue_vld0, issue_vld1;
  iq_pkg::iq_entry_t issue_entry0, issue_entry1;
  logic              cfg_we, cfg_addr, flush;
  logic [7:0]        cfg_wdata;
  logic [CW-1:0]     iq_count;

  iq_pkg::iq_entry_t model_q[$]; // Entries in dispatch order.
  int                model_limit, stim_limit;
  bit                model_dual, mon_on, prev_ack;
  bit                pend_ready, pend_flush, pend_we, pend_addr, pend_vld0, pend_vld1;
  logic [7:0]        pend_wdata;
  bit                acked;
  int                tries, waited;

  iq_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping the run");
  endtask

  task automatic report_mismatch(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_entry(input iq_pkg::iq_entry_t exp, input iq_pkg::iq_entry_t act,
                             input string what);
    if (act !== exp) begin
      report_mismatch($sformatf("%s: expected %h, got %h", what, exp, act));
    end
  endtask

  task automatic check_valid(input logic exp, input logic act, input string what);
    if (act !== exp) begin
      report_mismatch($sformatf("%s: expected %b, got %b", what, exp, act));
    end
  endtask

  task automatic check_count(input logic [CW-1:0] exp, input logic [CW-1:0] act);
    if (act !== exp) begin
      report_mismatch($sformatf("iq_count: expected %0d, got %0d", exp, act));
    end
  endtask

  // Written limit lands in 1..DEPTH.
  function automatic int clamp_limit(input logic [7:0] wdata);
    int lim;
    lim = int'(wdata);
    if (lim < 1) begin
      lim = 1;
    end else if (lim > DEPTH) begin
      lim = DEPTH;
    end
    return lim;
  endfunction

  // Loads and stores are the memory operations.
  function automatic bit touches_memory(input iq_pkg::iq_op_e op);
    return (op == iq_pkg::OP_LOAD) || (op == iq_pkg::OP_STORE);
  endfunction

  function automatic iq_pkg::iq_entry_t random_entry();
    iq_pkg::iq_entry_t e;
    e.op      = iq_pkg::iq_op_e'(3'($urandom % 5));
    e.tag     = 4'($urandom);
    e.payload = 16'($urandom);
    return e;
  endfunction

  // Called right after a rising edge.
  task automatic quiet_inputs(input bit rand_ready);
    cfg_we <= 1'b0;
    flush  <= 1'b0;
    if (rand_ready) begin
      issue_ready <= ($urandom % 4) != 0;
    end
  endtask

  task automatic write_cfg(input logic addr, input logic [7:0] wdata);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= wdata;
    if (!addr) begin
      stim_limit = clamp_limit(wdata);
    end
  endtask

  task automatic wait_ack(input bit rand_ready, input int max_wait, output bit seen);
    int n;
    n = 0;
    seen = 1'b0;
    while (!seen && n < max_wait) begin
      @(negedge clk);
      if (disp_ack) begin
        seen = 1'b1;
      end else begin
        @(posedge clk);
        quiet_inputs(rand_ready);
        n++;
      end
    end
  endtask

  task automatic send_bundle(input bit rand_ready, input int max_wait, output bit seen);
    @(posedge clk);
    quiet_inputs(rand_ready);
    disp_req    <= 1'b1;
    disp_two    <= (($urandom % 2) == 1) && (stim_limit >= 2);
    disp_entry0 <= random_entry();
    disp_entry1 <= random_entry();
    wait_ack(rand_ready, max_wait, seen);
  endtask

  task automatic release_bundle();
    int n;
    n = 0;
    @(posedge clk);
    quiet_inputs(1'b0);
    disp_req <= 1'b0;
    @(negedge clk);
    while (disp_ack && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (disp_ack) begin
      $display("disp_ack never fell after disp_req dropped");
      stop_run();
    end
  endtask

  // Model follows the last edge, then checks the outputs of this cycle.
  always @(negedge clk) begin
    int pre_size;
    if (mon_on) begin
      pre_size = model_q.size();
      if (pend_flush) begin
        model_q.delete();
      end else if (pend_ready) begin
        if (pend_vld0) void'(model_q.pop_front());
        if (pend_vld1) void'(model_q.pop_front());
      end
      if (disp_ack && !prev_ack) begin
        if (pre_size + (disp_two ? 2 : 1) > model_limit) begin
          report_mismatch("bundle accepted beyond the occupancy limit");
        end
        model_q.push_back(disp_entry0);
        if (disp_two) model_q.push_back(disp_entry1);
      end
      if (pend_we && !pend_addr) model_limit = clamp_limit(pend_wdata);
      if (pend_we && pend_addr) model_dual = pend_wdata[0];
      pend_vld0 = model_q.size() >= 1;
      pend_vld1 = 1'b0;
      if (model_q.size() >= 2) begin
        pend_vld1 = model_dual &&
          !(touches_memory(model_q[0].op) && touches_memory(model_q[1].op));
      end
      check_count(CW'(model_q.size()), iq_count);
      check_valid(pend_vld0, issue_vld0, "issue_vld0");
      check_valid(pend_vld1, issue_vld1, "issue_vld1");
      if (pend_vld0) check_entry(model_q[0], issue_entry0, "issue_entry0");
      if (pend_vld1) check_entry(model_q[1], issue_entry1, "issue_entry1");
      pend_ready = issue_ready;
      pend_flush = flush;
      pend_we    = cfg_we;
      pend_addr  = cfg_addr;
      pend_wdata = cfg_wdata;
      prev_ack   = disp_ack;
    end
  end

  initial begin
    void'($urandom(96847));
    arst_n      = 1'b0;
    disp_req    = 1'b0;
    disp_two    = 1'b0;
    disp_entry0 = '0;
    disp_entry1 = '0;
    issue_ready = 1'b0;
    cfg_we      = 1'b0;
    cfg_addr    = 1'b0;
    cfg_wdata   = '0;
    flush       = 1'b0;
    model_limit = DEPTH;
    stim_limit  = DEPTH;
    model_dual  = 1'b1;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    mon_on <= 1'b1;
    @(negedge clk);
    check_valid(1'b0, disp_ack, "disp_ack after reset");
    check_valid(1'b0, issue_vld0, "issue_vld0 after reset");
    check_valid(1'b0, issue_vld1, "issue_vld1 after reset");
    check_count('0, iq_count);

    // Random bundles, issue_ready, config writes and idle flushes.
    repeat (400) begin
      repeat ($urandom % 3) begin
        @(posedge clk);
        quiet_inputs(1'b1);
        case ($urandom % 16)
          0: flush <= 1'b1;
          1: write_cfg(1'b0, 8'($urandom % 11));
          2: write_cfg(1'b1, 8'($urandom % 2));
          default: ;
        endcase
      end
      send_bundle(1'b1, WAIT_LIMIT, acked);
      if (!acked) begin
        $display("disp_ack never rose for a dispatched bundle");
        stop_run();
      end
      release_bundle();
    end

    // Back-pressure at a limit of 4.
    @(posedge clk);
    quiet_inputs(1'b0);
    issue_ready <= 1'b0;
    write_cfg(1'b0, 8'd4);
    tries = 0;
    acked = 1'b1;
    while (acked && tries < 2 * DEPTH) begin
      send_bundle(1'b0, 20, acked);
      if (acked) release_bundle();
      tries++;
    end
    if (acked) begin
      $display("dispatch never stalled at the occupancy limit");
      stop_run();
    end
    @(posedge clk);
    issue_ready <= 1'b1;
    wait_ack(1'b0, WAIT_LIMIT, acked);
    if (!acked) begin
      $display("disp_ack never rose after issue_ready returned");
      stop_run();
    end
    release_bundle();

    // Leave a bundle queued, flush with the handshake idle, then refill.
    @(posedge clk);
    quiet_inputs(1'b0);
    issue_ready <= 1'b0;
    send_bundle(1'b0, WAIT_LIMIT, acked);
    if (!acked) begin
      $display("disp_ack never rose before the flush");
      stop_run();
    end
    release_bundle();
    @(posedge clk);
    quiet_inputs(1'b0);
    flush <= 1'b1;
    @(posedge clk);
    quiet_inputs(1'b0);
    @(negedge clk);
    check_count('0, iq_count);
    check_valid(1'b0, issue_vld0, "issue_vld0 after flush");
    check_valid(1'b0, issue_vld1, "issue_vld1 after flush");
    send_bundle(1'b0, WAIT_LIMIT, acked);
    if (!acked) begin
      $display("disp_ack never rose after the flush");
      stop_run();
    end
    release_bundle();

    @(posedge clk);
    issue_ready <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (iq_count != '0 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (iq_count != '0) begin
      $display("queue did not drain with issue_ready high");
      stop_run();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* src.f */
verilog/iq_pkg.sv
verilog/iq_if.sv
verilog/iq_cfg_regs.sv
verilog/dispatch_port.sv
verilog/issue_queue.sv
verilog/issue_select.sv
verilog/iq_top.sv
verif/tb_iq_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_iq_top \
  -f src.f \
  -o sim_iq

./obj_dir/sim_iq
